//--- verilog/rv_operand_consts.svh
`ifndef RV_OPERAND_CONSTS_SVH
`define RV_OPERAND_CONSTS_SVH

// Word width of the integer datapath
`define RV_XLEN 32

// Number of architectural integer registers
`define RV_NREGS 32

// Bits needed to index one register
`define RV_REG_AW 5

// CSR address field width from the instruction encoding
`define RV_CSR_AW 12

`endif

//--- verilog/rv_operand_pkg.sv
`include "rv_operand_consts.svh"

package rv_operand_pkg;

  // Machine-mode CSRs kept in this block
  // Every other address reads zero
  typedef enum logic [`RV_CSR_AW-1:0] {
    CSR_MSTATUS  = 12'h300,
    CSR_MSCRATCH = 12'h340,
    CSR_MEPC     = 12'h341,
    CSR_MCAUSE   = 12'h342
  } csr_addr_e;

  // Read-modify-write flavour, from funct3 low bits
  typedef enum logic [1:0] {
    CSR_RW = 2'b01,
    CSR_RS = 2'b10,
    CSR_RC = 2'b11
  } csr_op_e;

  // Writers sharing the rd write port
  typedef enum logic {
    WR_EXEC = 1'b0,
    WR_CSR  = 1'b1
  } writer_e;

endpackage

//--- verilog/rd_write_if.sv
`timescale 1ns/1ps
`include "rv_operand_consts.svh"

// One writer's path toward the register write port
// Request, rd and data hold until grant is seen at a clock edge
interface rd_write_if;
  logic                  req;
  logic [`RV_REG_AW-1:0] rd;
  logic [`RV_XLEN-1:0]   data;
  logic                  grant;

  // Writer side
  modport requester (output req, output rd, output data, input grant);

  // Arbiter side
  modport arbiter (input req, input rd, input data, output grant);
endinterface

//--- verilog/reg_file.sv
`timescale 1ns/1ps
`include "rv_operand_consts.svh"

module reg_file (
  input  logic                  clk,
  input  logic                  reset,
  input  logic [`RV_REG_AW-1:0] rs1,
  input  logic [`RV_REG_AW-1:0] rs2,
  input  logic                  wr_en,
  input  logic [`RV_REG_AW-1:0] wr_rd,
  input  logic [`RV_XLEN-1:0]   wr_data,
  output logic [`RV_XLEN-1:0]   operand1,
  output logic [`RV_XLEN-1:0]   operand2
);

  // Integer register array
  logic [`RV_XLEN-1:0] regs [`RV_NREGS];

  // Bypass selects for the two read ports
  logic byp1;
  logic byp2;

  // Real write only when the target is not x0
  logic wr_commit;

  assign wr_commit = wr_en && (wr_rd != '0);

  // Committing write forwarded to a matching read
  // x0 never matches, so a write aimed at x0 is invisible
  assign byp1 = wr_commit && (wr_rd == rs1);
  assign byp2 = wr_commit && (wr_rd == rs2);

  // Port 1 read
  always_comb begin
    if (rs1 == '0) begin
      operand1 = '0;
    end else if (byp1) begin
      operand1 = wr_data;
    end else begin
      operand1 = regs[rs1];
    end
  end

  // Port 2 read, same rules as port 1
  always_comb begin
    if (rs2 == '0) begin
      operand2 = '0;
    end else if (byp2) begin
      operand2 = wr_data;
    end else begin
      operand2 = regs[rs2];
    end
  end

  // Array update
  // Whole file cleared on reset
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `RV_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_commit) begin
      regs[wr_rd] <= wr_data;
    end
  end

endmodule

//--- verilog/csr_file.sv
`timescale 1ns/1ps
`include "rv_operand_consts.svh"

module csr_file (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    csr_valid,
  input  rv_operand_pkg::csr_op_e csr_op,
  input  logic [`RV_CSR_AW-1:0]   csr_addr,
  input  logic [`RV_XLEN-1:0]     csr_wdata,
  input  logic [`RV_REG_AW-1:0]   csr_rd,
  rd_write_if.requester           wr,
  output logic                    csr_busy,
  output logic                    mie
);
  import rv_operand_pkg::*;

  // Only the global interrupt enable survives in mstatus
  localparam int MIE_BIT = 3;

  // mepc is word aligned
  localparam logic [`RV_XLEN-1:0] MEPC_MASK = {{(`RV_XLEN-2){1'b1}}, 2'b00};

  // CSR storage
  logic                mstatus_mie;
  logic [`RV_XLEN-1:0] mscratch;
  logic [`RV_XLEN-1:0] mepc;
  logic [`RV_XLEN-1:0] mcause;

  // Current and updated value of the addressed CSR
  logic [`RV_XLEN-1:0] old_value;
  logic [`RV_XLEN-1:0] new_value;

  // Strobe taken this cycle
  logic accept;

  // Old-value writeback buffer, one entry
  logic                  wb_pending;
  logic [`RV_REG_AW-1:0] wb_rd;
  logic [`RV_XLEN-1:0]   wb_data;

  // Strobes arriving while the buffer is full are dropped
  assign accept = csr_valid && !wb_pending;

  // Readable view of the addressed CSR
  always_comb begin
    old_value = '0;
    case (csr_addr)
      CSR_MSTATUS:  old_value[MIE_BIT] = mstatus_mie;
      CSR_MSCRATCH: old_value = mscratch;
      CSR_MEPC:     old_value = mepc;
      CSR_MCAUSE:   old_value = mcause;
      default:      old_value = '0;
    endcase
  end

  // Op applied before the per-CSR masks
  always_comb begin
    case (csr_op)
      CSR_RW:  new_value = csr_wdata;
      CSR_RS:  new_value = old_value | csr_wdata;
      CSR_RC:  new_value = old_value & ~csr_wdata;
      default: new_value = old_value;
    endcase
  end

  // CSR update and buffer flag
  always_ff @(posedge clk) begin
    if (reset) begin
      mstatus_mie <= 1'b0;
      mscratch    <= '0;
      mepc        <= '0;
      mcause      <= '0;
      wb_pending  <= 1'b0;
    end else if (accept) begin
      case (csr_addr)
        CSR_MSTATUS:  mstatus_mie <= new_value[MIE_BIT];
        CSR_MSCRATCH: mscratch <= new_value;
        CSR_MEPC:     mepc <= new_value & MEPC_MASK;
        CSR_MCAUSE:   mcause <= new_value;
        default:      ;
      endcase
      // No writeback for rd = x0
      wb_pending <= (csr_rd != '0);
    end else if (wb_pending && wr.grant) begin
      // Register commit happens on this same edge
      wb_pending <= 1'b0;
    end
  end

  // Buffer payload captured with the strobe
  always_ff @(posedge clk) begin
    if (accept) begin
      wb_rd   <= csr_rd;
      wb_data <= old_value;
    end
  end

  // Request held until the arbiter grants it
  assign wr.req  = wb_pending;
  assign wr.rd   = wb_rd;
  assign wr.data = wb_data;

  assign csr_busy = wb_pending;
  assign mie      = mstatus_mie;

endmodule

//--- verilog/rd_write_arbiter.sv
`timescale 1ns/1ps
`include "rv_operand_consts.svh"

module rd_write_arbiter (
  input  logic                  clk,
  input  logic                  reset,
  rd_write_if.arbiter           exec_port,
  rd_write_if.arbiter           csr_port,
  output logic                  wr_en,
  output logic [`RV_REG_AW-1:0] wr_rd,
  output logic [`RV_XLEN-1:0]   wr_data
);
  import rv_operand_pkg::*;

  // Writer that took the port most recently
  writer_e last_winner;

  logic exec_gnt;
  logic csr_gnt;

  // A lone requester always wins
  // On a tie the writer that lost last time goes first
  assign exec_gnt = exec_port.req && (!csr_port.req || (last_winner == WR_CSR));
  assign csr_gnt  = csr_port.req && (!exec_port.req || (last_winner == WR_EXEC));

  assign exec_port.grant = exec_gnt;
  assign csr_port.grant  = csr_gnt;

  // Winner onto the register write port
  assign wr_en = exec_gnt || csr_gnt;

  always_comb begin
    if (csr_gnt) begin
      wr_rd   = csr_port.rd;
      wr_data = csr_port.data;
    end else begin
      wr_rd   = exec_port.rd;
      wr_data = exec_port.data;
    end
  end

  // Priority pointer
  // Starts as if the CSR writer had just won, so exec takes the first tie
  always_ff @(posedge clk) begin
    if (reset) begin
      last_winner <= WR_CSR;
    end else if (csr_gnt) begin
      last_winner <= WR_CSR;
    end else if (exec_gnt) begin
      last_winner <= WR_EXEC;
    end
  end

endmodule

//--- verilog/rv_operand_top.sv
`timescale 1ns/1ps
`include "rv_operand_consts.svh"

module rv_operand_top (
  input  logic                    clk,
  input  logic                    reset,
  input  logic [`RV_REG_AW-1:0]   rs1,
  input  logic [`RV_REG_AW-1:0]   rs2,
  input  logic                    exec_we,
  input  logic [`RV_REG_AW-1:0]   exec_rd,
  input  logic [`RV_XLEN-1:0]     exec_data,
  input  logic                    csr_valid,
  input  rv_operand_pkg::csr_op_e csr_op,
  input  logic [`RV_CSR_AW-1:0]   csr_addr,
  input  logic [`RV_XLEN-1:0]     csr_wdata,
  input  logic [`RV_REG_AW-1:0]   csr_rd,
  output logic [`RV_XLEN-1:0]     operand1,
  output logic [`RV_XLEN-1:0]     operand2,
  output logic                    exec_ready,
  output logic                    csr_busy,
  output logic                    mie
);

  // One bundle per rd writer
  rd_write_if exec_wr ();
  rd_write_if csr_wr ();

  // Shared register write port
  logic                  wr_en;
  logic [`RV_REG_AW-1:0] wr_rd;
  logic [`RV_XLEN-1:0]   wr_data;

  // Execute writeback comes straight from the top ports
  assign exec_wr.req  = exec_we;
  assign exec_wr.rd   = exec_rd;
  assign exec_wr.data = exec_data;
  assign exec_ready   = exec_wr.grant;

  csr_file u_csr_file (
    .clk       (clk),
    .reset     (reset),
    .csr_valid (csr_valid),
    .csr_op    (csr_op),
    .csr_addr  (csr_addr),
    .csr_wdata (csr_wdata),
    .csr_rd    (csr_rd),
    .wr        (csr_wr.requester),
    .csr_busy  (csr_busy),
    .mie       (mie)
  );

  rd_write_arbiter u_rd_write_arbiter (
    .clk       (clk),
    .reset     (reset),
    .exec_port (exec_wr.arbiter),
    .csr_port  (csr_wr.arbiter),
    .wr_en     (wr_en),
    .wr_rd     (wr_rd),
    .wr_data   (wr_data)
  );

  reg_file u_reg_file (
    .clk      (clk),
    .reset    (reset),
    .rs1      (rs1),
    .rs2      (rs2),
    .wr_en    (wr_en),
    .wr_rd    (wr_rd),
    .wr_data  (wr_data),
    .operand1 (operand1),
    .operand2 (operand2)
  );

endmodule

//--- verif/rv_operand_checker.sv
`timescale 1ns/1ps
`include "rv_operand_consts.svh"

module rv_operand_checker (
  input  logic                    clk,
  input  logic                    reset,
  input  logic [`RV_REG_AW-1:0]   rs1,
  input  logic [`RV_REG_AW-1:0]   rs2,
  input  logic                    exec_we,
  input  logic [`RV_REG_AW-1:0]   exec_rd,
  input  logic [`RV_XLEN-1:0]     exec_data,
  input  logic                    csr_valid,
  input  rv_operand_pkg::csr_op_e csr_op,
  input  logic [`RV_CSR_AW-1:0]   csr_addr,
  input  logic [`RV_XLEN-1:0]     csr_wdata,
  input  logic [`RV_REG_AW-1:0]   csr_rd,
  input  logic [`RV_XLEN-1:0]     operand1,
  input  logic [`RV_XLEN-1:0]     operand2,
  input  logic                    exec_ready,
  input  logic                    csr_busy,
  input  logic                    mie,
  output int                      checks,
  output int                      errors
);
  import rv_operand_pkg::*;

  // Model state
  // CSR slots: mstatus, mscratch, mepc, mcause
  logic [`RV_XLEN-1:0]   reg_model [`RV_NREGS];
  logic [`RV_XLEN-1:0]   csr_model [4];
  logic                  pend;
  logic [`RV_REG_AW-1:0] pend_rd;
  logic [`RV_XLEN-1:0]   pend_data;
  writer_e               last_model;

  // Readable value of a CSR, zero for unknown addresses
  function automatic logic [`RV_XLEN-1:0] expected_old(input logic [`RV_CSR_AW-1:0] addr);
    case (addr)
      CSR_MSTATUS:  expected_old = csr_model[0];
      CSR_MSCRATCH: expected_old = csr_model[1];
      CSR_MEPC:     expected_old = csr_model[2];
      CSR_MCAUSE:   expected_old = csr_model[3];
      default:      expected_old = '0;
    endcase
  endfunction

  // Op first, then the per-CSR mask
  function automatic logic [`RV_XLEN-1:0] expected_csr(input logic [`RV_CSR_AW-1:0] addr,
      input csr_op_e op, input logic [`RV_XLEN-1:0] wdata, input logic [`RV_XLEN-1:0] old);
    logic [`RV_XLEN-1:0] v;
    case (op)
      CSR_RW:  v = wdata;
      CSR_RS:  v = old | wdata;
      CSR_RC:  v = old & ~wdata;
      default: v = old;
    endcase
    case (addr)
      CSR_MSTATUS: expected_csr = v & 32'h0000_0008;
      CSR_MEPC:    expected_csr = v & 32'hffff_fffc;
      default:     expected_csr = v;
    endcase
  endfunction

  // Lone requester wins, a tie goes to the writer that lost last
  function automatic writer_e expected_grant(input logic exec_req, input logic csr_req,
      input writer_e last);
    if (exec_req && csr_req) begin
      expected_grant = (last == WR_CSR) ? WR_EXEC : WR_CSR;
    end else if (csr_req) begin
      expected_grant = WR_CSR;
    end else begin
      expected_grant = WR_EXEC;
    end
  endfunction

  // x0 reads zero, a committing write is forwarded
  function automatic logic [`RV_XLEN-1:0] expected_operand(input logic [`RV_REG_AW-1:0] idx,
      input logic commit, input logic [`RV_REG_AW-1:0] c_rd, input logic [`RV_XLEN-1:0] c_data);
    if (idx == '0) begin
      expected_operand = '0;
    end else if (commit && (c_rd == idx)) begin
      expected_operand = c_data;
    end else begin
      expected_operand = reg_model[idx];
    end
  endfunction

  task automatic compare(input string what, input logic [`RV_XLEN-1:0] got,
      input logic [`RV_XLEN-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR t=%0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  initial begin
    checks = 0;
    errors = 0;
  end

  // Outputs are settled mid-cycle; the model then steps over the coming edge
  always @(negedge clk) begin : watch
    logic                  any_req;
    logic                  busy_now;
    logic                  commit;
    writer_e               win;
    logic [`RV_REG_AW-1:0] c_rd;
    logic [`RV_XLEN-1:0]   c_data;
    logic [`RV_XLEN-1:0]   old_v;
    if (reset) begin
      for (int i = 0; i < `RV_NREGS; i++) begin
        reg_model[i] = '0;
      end
      for (int i = 0; i < 4; i++) begin
        csr_model[i] = '0;
      end
      pend       = 1'b0;
      last_model = WR_CSR;
    end else begin
      busy_now = pend;
      any_req  = exec_we || pend;
      win      = expected_grant(exec_we, pend, last_model);
      c_rd     = (win == WR_CSR) ? pend_rd : exec_rd;
      c_data   = (win == WR_CSR) ? pend_data : exec_data;
      commit   = any_req && (c_rd != '0);
      compare("exec_ready", exec_ready, exec_we && (win == WR_EXEC));
      compare("csr_busy", csr_busy, pend);
      compare("mie", mie, csr_model[0][3]);
      compare($sformatf("operand1 x%0d", rs1), operand1,
        expected_operand(rs1, commit, c_rd, c_data));
      compare($sformatf("operand2 x%0d", rs2), operand2,
        expected_operand(rs2, commit, c_rd, c_data));
      // Register commit at the edge
      if (any_req) begin
        if (c_rd != '0) begin
          reg_model[c_rd] = c_data;
        end
        last_model = win;
        if (win == WR_CSR) begin
          pend = 1'b0;
        end
      end
      // Strobe taken only with an empty buffer
      if (csr_valid && !busy_now) begin
        old_v = expected_old(csr_addr);
        case (csr_addr)
          CSR_MSTATUS:  csr_model[0] = expected_csr(csr_addr, csr_op, csr_wdata, old_v);
          CSR_MSCRATCH: csr_model[1] = expected_csr(csr_addr, csr_op, csr_wdata, old_v);
          CSR_MEPC:     csr_model[2] = expected_csr(csr_addr, csr_op, csr_wdata, old_v);
          CSR_MCAUSE:   csr_model[3] = expected_csr(csr_addr, csr_op, csr_wdata, old_v);
          default:      ;
        endcase
        pend      = (csr_rd != '0);
        pend_rd   = csr_rd;
        pend_data = old_v;
      end
    end
  end

endmodule

//--- verif/tb_rv_operand.sv
`timescale 1ns/1ps
`include "rv_operand_consts.svh"

module tb_rv_operand;
  import rv_operand_pkg::*;

  localparam int N_EXEC     = 40;
  localparam int N_BYP      = 8;
  localparam int N_CSR      = 30;
  localparam int N_RR       = 20;
  localparam int WAIT_LIMIT = 8;
  // Rough cycle budget over all five tests
  localparam int TEST_CYCLES = 10 + 5 * (`RV_NREGS + 4) + 4 * (N_EXEC + N_BYP)
                               + 8 * (N_CSR + N_RR);
  localparam int MARGIN_NS  = 2000;

  logic                  clk;
  logic                  reset;
  logic [`RV_REG_AW-1:0] rs1;
  logic [`RV_REG_AW-1:0] rs2;
  logic                  exec_we;
  logic [`RV_REG_AW-1:0] exec_rd;
  logic [`RV_XLEN-1:0]   exec_data;
  logic                  csr_valid;
  csr_op_e               csr_op;
  logic [`RV_CSR_AW-1:0] csr_addr;
  logic [`RV_XLEN-1:0]   csr_wdata;
  logic [`RV_REG_AW-1:0] csr_rd;
  logic [`RV_XLEN-1:0]   operand1;
  logic [`RV_XLEN-1:0]   operand2;
  logic                  exec_ready;
  logic                  csr_busy;
  logic                  mie;

  // Bookkeeping
  int          checks;
  int          errors;
  int          hang_fails;
  int          tests_ok;
  int          tests_bad;
  int          fails_seen;
  logic [31:0] lcg_state;

  rv_operand_top u_rv_operand_top (.*);

  rv_operand_checker u_checker (.*);

  always #5 clk = ~clk;

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic next_rand(output logic [31:0] v);
    lcg_state = lcg_step(lcg_state);
    v = lcg_state;
  endtask

  // 0x305 is mtvec and not kept here
  function automatic logic [`RV_CSR_AW-1:0] pick_csr(input logic [31:0] r);
    case (r % 5)
      0:       pick_csr = CSR_MSTATUS;
      1:       pick_csr = CSR_MSCRATCH;
      2:       pick_csr = CSR_MEPC;
      3:       pick_csr = CSR_MCAUSE;
      default: pick_csr = 12'h305;
    endcase
  endfunction

  function automatic csr_op_e pick_op(input logic [31:0] r);
    case (r % 3)
      0:       pick_op = CSR_RW;
      1:       pick_op = CSR_RS;
      default: pick_op = CSR_RC;
    endcase
  endfunction

  // Request held until exec_ready and dropped after the grant edge
  task automatic exec_write(input logic [4:0] rd, input logic [31:0] data, input logic peek);
    int waited;
    @(posedge clk);
    exec_we   <= 1'b1;
    exec_rd   <= rd;
    exec_data <= data;
    if (peek) begin
      rs1 <= rd;
      rs2 <= rd;
    end
    waited = 0;
    @(negedge clk);
    while (!exec_ready && waited < WAIT_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (!exec_ready) begin
      $display("Exec write to x%0d was never granted within %0d cycles", rd, WAIT_LIMIT);
      hang_fails++;
    end
    @(posedge clk);
    exec_we <= 1'b0;
  endtask

  // hold keeps the strobe up for one more cycle
  task automatic csr_access(input csr_op_e op, input logic [11:0] addr,
      input logic [31:0] wdata, input logic [4:0] rd, input logic hold);
    int waited;
    @(posedge clk);
    csr_valid <= 1'b1;
    csr_op    <= op;
    csr_addr  <= addr;
    csr_wdata <= wdata;
    csr_rd    <= rd;
    if (hold) begin
      @(posedge clk);
      csr_wdata <= ~wdata;
    end
    @(posedge clk);
    csr_valid <= 1'b0;
    waited = 0;
    @(negedge clk);
    while (csr_busy && waited < WAIT_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (csr_busy) begin
      $display("csr_busy stayed high %0d cycles after an access to CSR %h", waited, addr);
      hang_fails++;
    end
  endtask

  task automatic read_sweep();
    for (int i = 0; i < `RV_NREGS; i++) begin
      @(posedge clk);
      rs1 <= 5'(i);
      rs2 <= 5'(`RV_NREGS - 1 - i);
    end
    repeat (2) @(posedge clk);
  endtask

  task automatic end_test(input string name);
    int fails_now;
    fails_now = errors + hang_fails;
    if (fails_now == fails_seen) begin
      tests_ok++;
      $display("[PASS] %s", name);
    end else begin
      tests_bad++;
      $display("[FAIL] %s, %0d new failures", name, fails_now - fails_seen);
    end
    fails_seen = fails_now;
  endtask

  initial begin
    logic [31:0] r1;
    logic [31:0] r2;
    logic [31:0] r3;
    logic [4:0]  rr_rd;
    clk        = 1'b0;
    reset      = 1'b1;
    rs1        = '0;
    rs2        = '0;
    exec_we    = 1'b0;
    exec_rd    = '0;
    exec_data  = '0;
    csr_valid  = 1'b0;
    csr_op     = CSR_RW;
    csr_addr   = '0;
    csr_wdata  = '0;
    csr_rd     = '0;
    lcg_state  = 32'd6;
    hang_fails = 0;
    tests_ok   = 0;
    tests_bad  = 0;
    fails_seen = 0;
    repeat (10) @(posedge clk);
    reset <= 1'b0;

    read_sweep();
    end_test("reset state");

    // x0 write first and never visible
    exec_write(5'd0, 32'hdead_beef, 1'b0);
    for (int n = 0; n < N_EXEC; n++) begin
      next_rand(r1);
      next_rand(r2);
      exec_write(r1[31:27], r2, 1'b0);
    end
    read_sweep();
    end_test("exec writes");

    for (int n = 0; n < N_BYP; n++) begin
      next_rand(r1);
      next_rand(r2);
      exec_write(r1[31:27] | 5'd1, r2, 1'b1);
    end
    repeat (2) @(posedge clk);
    end_test("read bypass");

    // Old value read back from rd once busy drops
    for (int n = 0; n < N_CSR; n++) begin
      next_rand(r1);
      next_rand(r2);
      next_rand(r3);
      csr_access(pick_op(r1), pick_csr(r2), r3, r1[31:27], r2[31]);
      @(posedge clk);
      rs1 <= r1[31:27];
      rs2 <= r1[31:27];
    end
    read_sweep();
    end_test("csr operations");

    // Exec delay pattern 0, 1, 2, 1 sets up ties after either writer won last
    // Both writers aim at one rd so the read after each pair shows commit order
    for (int n = 0; n < N_RR; n++) begin
      next_rand(r1);
      next_rand(r2);
      next_rand(r3);
      rr_rd = r1[31:27] | 5'd1;
      fork
        csr_access(pick_op(r1), pick_csr(r2), r3, rr_rd, 1'b0);
        begin
          repeat ((n % 2 == 1) ? 1 : n % 4) @(posedge clk);
          exec_write(rr_rd, r2, 1'b0);
        end
      join
      @(posedge clk);
      rs1 <= rr_rd;
      rs2 <= rr_rd;
    end
    read_sweep();
    end_test("round-robin arbitration");

    $display("Summary: %0d tests ok, %0d tests bad, %0d checks, %0d errors, %0d stalls",
      tests_ok, tests_bad, checks, errors, hang_fails);
    if (tests_bad == 0 && errors == 0 && hang_fails == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(TEST_CYCLES * 20 + MARGIN_NS);
    $display("Timeout: run still going after %0d ns, a test is stuck",
      TEST_CYCLES * 20 + MARGIN_NS);
    $display("test failed");
    $finish;
  end

endmodule

//--- rv_operand.f
+incdir+verilog
verilog/rv_operand_pkg.sv
verilog/rd_write_if.sv
verilog/reg_file.sv
verilog/csr_file.sv
verilog/rd_write_arbiter.sv
verilog/rv_operand_top.sv
verif/rv_operand_checker.sv
verif/tb_rv_operand.sv
